// File: common/carfield_pkg.sv
/*
  SoC address map and bus widths.
  The L2 span size depends on the L2BankWords module parameter, so only
  its base lives here. The linear window starts at L2Base + 8*L2BankWords.
  Mailbox offsets assume word-aligned accesses; byte lanes are ignored.
*/
package carfield_pkg;

  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;

  // L2 span base, interleaved window first
  localparam logic [AddrWidth-1:0] L2Base = 32'h7800_0000;

  // Safety island mailbox
  localparam logic [AddrWidth-1:0] SafetyIslandBase  = 32'h6000_0000;
  localparam int unsigned          SafetyIslandWords = 4;

  // Decoder targets
  typedef enum logic [1:0] {
    TgtNone   = 2'd0,
    TgtL2     = 2'd1,
    TgtSafety = 2'd2
  } target_e;

  // Mailbox word offsets
  typedef enum logic [1:0] {
    MboxScratch0 = 2'd0,
    MboxScratch1 = 2'd1,
    MboxScratch2 = 2'd2,
    MboxDoorbell = 2'd3
  } mbox_reg_e;

endpackage

// File: common/car_l2_pkg.sv
/*
  L2 organization.
  Bank count must be a power of two. Each addressing window spans
  L2NumBanks * L2BankWords words. The two windows alias the same storage.
*/
package car_l2_pkg;

  localparam int unsigned L2NumBanks = 2;

  // Window select, taken from the offset bit above the window size
  typedef enum logic {
    L2Interleaved = 1'b0,
    L2Linear      = 1'b1
  } l2_mode_e;

endpackage

// File: common/mem_bus_if.sv
/*
  Request/response bundle between the address decoder and a target.
  req is a single-cycle strobe, addr is the word offset in the target
  region. rdata is valid in the cycle after a read strobe. No back-pressure.
*/
`timescale 1ns/10ps

interface mem_bus_if;

  logic                               req;
  logic                               we;
  logic [carfield_pkg::AddrWidth-3:0] addr;
  logic [carfield_pkg::DataWidth-1:0] wdata;
  logic [carfield_pkg::DataWidth-1:0] rdata;

  modport host (
    output req, we, addr, wdata,
    input  rdata
  );

  modport device (
    input  req, we, addr, wdata,
    output rdata
  );

endinterface

// File: l2/l2_bank.sv
/*
  Single-port word memory, no reset on contents.
  Write at the enabled edge; read data registered, valid next cycle.
*/
`timescale 1ns/10ps

module l2_bank #(
  parameter int unsigned L2BankWords = 256
) (
  input  logic                               clk_i,
  input  logic                               en_i,
  input  logic                               we_i,
  input  logic [$clog2(L2BankWords)-1:0]     row_i,
  input  logic [carfield_pkg::DataWidth-1:0] wdata_i,
  output logic [carfield_pkg::DataWidth-1:0] rdata_o
);

  logic [carfield_pkg::DataWidth-1:0] mem [L2BankWords];

  always_ff @(posedge clk_i) begin
    if (en_i) begin
      if (we_i) begin
        mem[row_i] <= wdata_i;
      end else begin
        rdata_o <= mem[row_i];
      end
    end
  end

endmodule

// File: l2/car_l2_top.sv
/*
  Reconfigurable L2 with two aliased windows over the same banks.
  Interleaved: low word bits pick the bank. Linear: bank 0 first, then
  bank 1. Offsets above the two windows are not expected here; the
  decoder filters them. Read data is valid one cycle after the strobe.
*/
`timescale 1ns/10ps

module car_l2_top #(
  parameter int unsigned L2BankWords = 256
) (
  input  logic       clk_i,
  mem_bus_if.device  bus_i
);

  localparam int unsigned RowBits  = $clog2(L2BankWords);
  localparam int unsigned BankBits = $clog2(car_l2_pkg::L2NumBanks);

  car_l2_pkg::l2_mode_e mode;
  logic [BankBits-1:0]  bank_sel;
  logic [BankBits-1:0]  bank_q;
  logic [RowBits-1:0]   row;
  logic [carfield_pkg::DataWidth-1:0] bank_rdata [car_l2_pkg::L2NumBanks];

  // Window select sits just above the window offset
  assign mode = car_l2_pkg::l2_mode_e'(bus_i.addr[RowBits+BankBits]);

  always_comb begin
    if (mode == car_l2_pkg::L2Interleaved) begin
      bank_sel = bus_i.addr[BankBits-1:0];
      row      = bus_i.addr[RowBits+BankBits-1:BankBits];
    end else begin
      bank_sel = bus_i.addr[RowBits+BankBits-1:RowBits];
      row      = bus_i.addr[RowBits-1:0];
    end
  end

  for (genvar b = 0; b < car_l2_pkg::L2NumBanks; b++) begin : gen_bank
    l2_bank #(
      .L2BankWords ( L2BankWords )
    ) i_l2_bank (
      .clk_i   ( clk_i                                  ),
      .en_i    ( bus_i.req && (bank_sel == BankBits'(b)) ),
      .we_i    ( bus_i.we                               ),
      .row_i   ( row                                    ),
      .wdata_i ( bus_i.wdata                            ),
      .rdata_o ( bank_rdata[b]                          )
    );
  end

  // Remember which bank answers next cycle
  always_ff @(posedge clk_i) begin
    if (bus_i.req) begin
      bank_q <= bank_sel;
    end
  end

  assign bus_i.rdata = bank_rdata[bank_q];

endmodule

// File: safety_island/safety_mailbox.sv
/*
  Safety island mailbox: three scratch words and a doorbell.
  Bit 0 of a doorbell write sets the interrupt level directly.
  Reads return data one cycle after the strobe; doorbell reads give
  the level in bit 0.
*/
`timescale 1ns/10ps

module safety_mailbox (
  input  logic       clk_i,
  input  logic       rst_i,
  mem_bus_if.device  bus_i,
  output logic       safety_irq_o
);

  localparam int unsigned RegBits = $clog2(carfield_pkg::SafetyIslandWords);

  carfield_pkg::mbox_reg_e            reg_sel;
  logic [carfield_pkg::DataWidth-1:0] scratch_q [3];
  logic                               doorbell_q;
  logic [carfield_pkg::DataWidth-1:0] rdata_q;

  assign reg_sel = carfield_pkg::mbox_reg_e'(bus_i.addr[RegBits-1:0]);

  // Control and scratch state
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      scratch_q[0] <= '0;
      scratch_q[1] <= '0;
      scratch_q[2] <= '0;
      doorbell_q   <= 1'b0;
    end else if (bus_i.req && bus_i.we) begin
      if (reg_sel == carfield_pkg::MboxDoorbell) begin
        doorbell_q <= bus_i.wdata[0];
      end else begin
        scratch_q[reg_sel] <= bus_i.wdata;
      end
    end
  end

  // Read path
  always_ff @(posedge clk_i) begin
    if (bus_i.req && !bus_i.we) begin
      if (reg_sel == carfield_pkg::MboxDoorbell) begin
        rdata_q <= {{(carfield_pkg::DataWidth-1){1'b0}}, doorbell_q};
      end else begin
        rdata_q <= scratch_q[reg_sel];
      end
    end
  end

  assign bus_i.rdata  = rdata_q;
  assign safety_irq_o = doorbell_q;

endmodule

// File: hw/periph_demux.sv
/*
  Host address decoder.
  Requests are forwarded combinationally; the response tag is registered
  for one cycle. Unmapped accesses complete with err_o and zero data.
  Byte offset bits [1:0] are dropped, so accesses are word-wide.
*/
`timescale 1ns/10ps

module periph_demux #(
  parameter int unsigned L2BankWords = 256
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [carfield_pkg::AddrWidth-1:0] addr_i,
  input  logic [carfield_pkg::DataWidth-1:0] wdata_i,
  output logic [carfield_pkg::DataWidth-1:0] rdata_o,
  output logic                               rvalid_o,
  output logic                               err_o,
  mem_bus_if.host                            l2_o,
  mem_bus_if.host                            safety_o
);

  // Two aliased windows of L2NumBanks * L2BankWords words each
  localparam logic [carfield_pkg::AddrWidth-1:0] L2SpanBytes =
    2 * car_l2_pkg::L2NumBanks * L2BankWords * 4;
  localparam logic [carfield_pkg::AddrWidth-1:0] MboxBytes =
    carfield_pkg::SafetyIslandWords * 4;

  logic [carfield_pkg::AddrWidth-1:0] l2_off;
  logic [carfield_pkg::AddrWidth-1:0] sf_off;
  carfield_pkg::target_e              tgt;
  carfield_pkg::target_e              tgt_q;
  logic                               rvalid_q;
  logic                               we_q;

  // Offsets wrap below the base, so one unsigned compare covers both bounds
  assign l2_off = addr_i - carfield_pkg::L2Base;
  assign sf_off = addr_i - carfield_pkg::SafetyIslandBase;

  always_comb begin
    tgt = carfield_pkg::TgtNone;
    if (l2_off < L2SpanBytes) begin
      tgt = carfield_pkg::TgtL2;
    end else if (sf_off < MboxBytes) begin
      tgt = carfield_pkg::TgtSafety;
    end
  end

  assign l2_o.req   = req_i && (tgt == carfield_pkg::TgtL2);
  assign l2_o.we    = we_i;
  assign l2_o.addr  = l2_off[carfield_pkg::AddrWidth-1:2];
  assign l2_o.wdata = wdata_i;

  assign safety_o.req   = req_i && (tgt == carfield_pkg::TgtSafety);
  assign safety_o.we    = we_i;
  assign safety_o.addr  = sf_off[carfield_pkg::AddrWidth-1:2];
  assign safety_o.wdata = wdata_i;

  // Response tag
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
      we_q     <= 1'b0;
      tgt_q    <= carfield_pkg::TgtNone;
    end else begin
      rvalid_q <= req_i;
      we_q     <= we_i;
      tgt_q    <= tgt;
    end
  end

  assign rvalid_o = rvalid_q;
  assign err_o    = rvalid_q && (tgt_q == carfield_pkg::TgtNone);

  always_comb begin
    rdata_o = '0;
    if (rvalid_q && !we_q) begin
      case (tgt_q)
        carfield_pkg::TgtL2:     rdata_o = l2_o.rdata;
        carfield_pkg::TgtSafety: rdata_o = safety_o.rdata;
        default:                 rdata_o = '0;
      endcase
    end
  end

endmodule

// File: hw/carfield_top.sv
/*
  Reduced SoC top: one host request port, L2 memory and safety mailbox.
  Every req_i gets rvalid_o exactly one cycle later; err_o marks unmapped
  addresses. L2BankWords must be a power of two.
*/
`timescale 1ns/10ps

module carfield_top #(
  parameter int unsigned L2BankWords = 256
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  logic                               req_i,
  input  logic                               we_i,
  input  logic [carfield_pkg::AddrWidth-1:0] addr_i,
  input  logic [carfield_pkg::DataWidth-1:0] wdata_i,
  output logic [carfield_pkg::DataWidth-1:0] rdata_o,
  output logic                               rvalid_o,
  output logic                               err_o,
  output logic                               safety_irq_o
);

  mem_bus_if l2_bus ();
  mem_bus_if safety_bus ();

  periph_demux #(
    .L2BankWords ( L2BankWords )
  ) i_periph_demux (
    .clk_i    ( clk_i             ),
    .rst_i    ( rst_i             ),
    .req_i    ( req_i             ),
    .we_i     ( we_i              ),
    .addr_i   ( addr_i            ),
    .wdata_i  ( wdata_i           ),
    .rdata_o  ( rdata_o           ),
    .rvalid_o ( rvalid_o          ),
    .err_o    ( err_o             ),
    .l2_o     ( l2_bus.host       ),
    .safety_o ( safety_bus.host   )
  );

  // Reconfigurable L2
  car_l2_top #(
    .L2BankWords ( L2BankWords )
  ) i_reconfigurable_l2 (
    .clk_i ( clk_i         ),
    .bus_i ( l2_bus.device )
  );

  // Safety island
  safety_mailbox i_safety_mailbox (
    .clk_i        ( clk_i             ),
    .rst_i        ( rst_i             ),
    .bus_i        ( safety_bus.device ),
    .safety_irq_o ( safety_irq_o      )
  );

endmodule

// File: dv/carfield_checker.sv
/*
  Concurrent protocol assertions, bound to carfield_top.
  Checks the fixed one-cycle response and the error and data rules.
*/
`timescale 1ns/10ps

module carfield_checker (
  input logic                               clk_i,
  input logic                               rst_i,
  input logic                               req_i,
  input logic                               rvalid_i,
  input logic                               err_i,
  input logic [carfield_pkg::DataWidth-1:0] rdata_i
);

  a_rvalid_after_req: assert property (@(posedge clk_i) disable iff (rst_i)
    req_i |=> rvalid_i) else $error("rvalid_o missing one cycle after req_i");

  a_no_stray_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    !req_i |=> !rvalid_i) else $error("rvalid_o high without a request");

  // Unmapped responses carry no data
  a_err_with_rvalid: assert property (@(posedge clk_i) disable iff (rst_i)
    err_i |-> rvalid_i && (rdata_i == '0))
    else $error("err_o high without rvalid_o or with nonzero rdata_o");

  a_rdata_known: assert property (@(posedge clk_i) disable iff (rst_i)
    rvalid_i |-> !$isunknown(rdata_i)) else $error("rdata_o unknown during rvalid_o");

endmodule

bind carfield_top carfield_checker i_checker (
  .clk_i    ( clk_i    ),
  .rst_i    ( rst_i    ),
  .req_i    ( req_i    ),
  .rvalid_i ( rvalid_o ),
  .err_i    ( err_o    ),
  .rdata_i  ( rdata_o  )
);

// File: dv/tb_carfield.sv
/*
  Directed testbench for carfield_top with 256-word banks.
  Inputs change on the falling edge, outputs are sampled there too.
  The L2 model is indexed as bank * BankWords + row.
*/
`timescale 1ns/10ps

module tb_carfield;

  localparam int          ClkPeriod   = 40;
  localparam int          ResetCycles = 16;
  localparam int          BankWords   = 256;
  localparam int          BurstWords  = 16;
  localparam logic [31:0] L2Base      = 32'h7800_0000;
  localparam logic [31:0] MboxBase    = 32'h6000_0000;
  // Upper bound on cycles used by all tests
  localparam int          NumOps = ResetCycles + 4 * (BurstWords + 1) + 2 * (3 * BurstWords + 8);

  logic        clk;
  logic        rst;
  logic        req;
  logic        we;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic [31:0] rdata;
  logic        rvalid;
  logic        err;
  logic        safety_irq;

  logic [31:0] l2_model [2 * BankWords];
  logic [31:0] scratch_model [3];
  logic [31:0] rng;
  int          errors;
  int          checks;

  carfield_top #(
    .L2BankWords ( BankWords )
  ) dut_i (
    .clk_i        ( clk        ),
    .rst_i        ( rst        ),
    .req_i        ( req        ),
    .we_i         ( we         ),
    .addr_i       ( addr       ),
    .wdata_i      ( wdata      ),
    .rdata_o      ( rdata      ),
    .rvalid_o     ( rvalid     ),
    .err_o        ( err        ),
    .safety_irq_o ( safety_irq )
  );

  always #(ClkPeriod / 2) clk = ~clk;

  function automatic logic [31:0] next_random();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Interleaved word w lives in bank w mod 2, row w / 2
  function automatic int model_index(input logic linear, input int idx);
    return linear ? idx : (idx % 2) * BankWords + idx / 2;
  endfunction

  function automatic logic [31:0] l2_addr(input logic linear, input int idx);
    return L2Base + (linear ? 8 * BankWords : 0) + 4 * idx;
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  // One isolated request, response checked one cycle later
  task automatic access(input logic write, input logic [31:0] a, input logic [31:0] d,
                        input logic exp_err, input logic [31:0] exp_rdata);
    @(negedge clk);
    req = 1'b1;
    we = write;
    addr = a;
    wdata = d;
    @(negedge clk);
    check_value("rvalid_o", rvalid, 1);
    check_value("err_o", err, exp_err);
    check_value("rdata_o", rdata, exp_rdata);
    req = 1'b0;
    we = 1'b0;
  endtask

  // Back-to-back L2 requests, each response checked while the next is issued
  task automatic burst(input logic write, input logic linear, input int first,
                       input int count);
    int          i;
    int          idx;
    logic [31:0] exp_rdata;
    exp_rdata = '0;
    for (i = 0; i <= count; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_value("rvalid_o", rvalid, 1);
        check_value("err_o", err, 0);
        check_value("rdata_o", rdata, exp_rdata);
      end
      if (i < count) begin
        idx = model_index(linear, first + i);
        req = 1'b1;
        we = write;
        addr = l2_addr(linear, first + i);
        wdata = write ? next_random() : '0;
        if (write) begin
          l2_model[idx] = wdata;
        end
        exp_rdata = write ? '0 : l2_model[idx];
      end else begin
        req = 1'b0;
        we = 1'b0;
      end
    end
  endtask

  // Outputs still hold the values from the last reset edge
  task automatic reset_state();
    check_value("rvalid_o", rvalid, 0);
    check_value("err_o", err, 0);
    check_value("safety_irq_o", safety_irq, 0);
  endtask

  task automatic interleaved_roundtrip();
    burst(1'b1, 1'b0, 0, BurstWords);
    burst(1'b0, 1'b0, 0, BurstWords);
  endtask

  task automatic window_aliasing();
    int w;
    int j;
    for (w = 0; w < BurstWords; w++) begin
      j = (w % 2) * BankWords + w / 2;
      access(1'b0, l2_addr(1'b1, j), '0, 1'b0, l2_model[model_index(1'b0, w)]);
    end
    // Linear writes across the bank boundary, read back through interleaving
    burst(1'b1, 1'b1, BankWords - 4, 8);
    for (j = BankWords - 4; j < BankWords + 4; j++) begin
      w = 2 * (j % BankWords) + j / BankWords;
      access(1'b0, l2_addr(1'b0, w), '0, 1'b0, l2_model[j]);
    end
  endtask

  task automatic mailbox_access();
    int i;
    for (i = 0; i < 3; i++) begin
      scratch_model[i] = next_random();
      access(1'b1, MboxBase + 4 * i, scratch_model[i], 1'b0, '0);
    end
    for (i = 0; i < 3; i++) begin
      access(1'b0, MboxBase + 4 * i, '0, 1'b0, scratch_model[i]);
    end
    access(1'b1, MboxBase + 12, 32'h8000_0001, 1'b0, '0);
    check_value("safety_irq_o", safety_irq, 1);
    access(1'b0, MboxBase + 12, '0, 1'b0, 32'd1);
    access(1'b1, MboxBase + 12, 32'hffff_fffe, 1'b0, '0);
    check_value("safety_irq_o", safety_irq, 0);
    access(1'b0, MboxBase + 12, '0, 1'b0, 32'd0);
  endtask

  task automatic unmapped_errors();
    access(1'b1, MboxBase + 16, next_random(), 1'b1, '0);
    access(1'b0, MboxBase + 16, '0, 1'b1, '0);
    access(1'b1, L2Base + 16 * BankWords, next_random(), 1'b1, '0);
    access(1'b0, L2Base + 16 * BankWords, '0, 1'b1, '0);
    access(1'b0, 32'h0000_0000, '0, 1'b1, '0);
    burst(1'b0, 1'b0, 0, BurstWords);
  endtask

  initial begin
    #(NumOps * ClkPeriod * 4);
    $display("Timeout: the tests did not finish within %0t", $time);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    // An unmapped request held during reset must not get a response
    req = 1'b1;
    we = 1'b0;
    addr = '0;
    wdata = '0;
    rng = 32'h28cd;
    errors = 0;
    checks = 0;
    repeat (ResetCycles) @(negedge clk);
    rst = 1'b0;
    req = 1'b0;
    reset_state();
    interleaved_roundtrip();
    window_aliasing();
    mailbox_access();
    unmapped_errors();
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
common/carfield_pkg.sv
common/car_l2_pkg.sv
common/mem_bus_if.sv
l2/l2_bank.sv
l2/car_l2_top.sv
safety_island/safety_mailbox.sv
hw/periph_demux.sv
hw/carfield_top.sv
dv/carfield_checker.sv
dv/tb_carfield.sv
